// File: sources.f
+incdir+design
design/dcache_cpu_pkg.sv
design/dcache_mem_pkg.sv
design/dcache_wb_if.sv
design/dcache_store.sv
design/dcache_wbuf.sv
design/dcache_ctrl.sv
design/dcache.sv
test/dcache_mem_model.sv
test/tb_dcache.sv

// File: Makefile
# Verilator simulation of the data cache

VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
    localparam int TIMEOUT = 400;      // cycles allowed per access

    logic        clk;
    logic        rst_n;
    logic        valid;
    logic        op;
    logic [31:0] addr;
    logic [3:0]  write_type;
    logic [31:0] w_data_cpu;
    logic        data_valid;
    logic [31:0] r_data_cpu;
    logic        r_req, r_data_ready, r_rdy, ret_valid, ret_last;
    logic [31:0] r_addr, r_data_axi;
    logic        w_req, w_data_req, w_last, b_ready, w_rdy, w_data_ready, b_valid;
    logic [31:0] w_addr, w_data_axi;
    logic [3:0]  w_strb;

    logic [31:0] ref_mem [logic [29:0]];   // mirrors every CPU write
    logic [31:0] cur_line = '0;
    logic [31:0] wb_base = '0;
    logic        dv_q = 1'b0;
    int          wb_beat;
    int          wb_count;
    int          errors;
    int          checks;
    int          tests;
    int          tests_failed;
    int          test_err0;
    string       test_name;

    dcache u_dcache (
        .clk, .rst_n, .valid, .op, .addr, .write_type, .w_data_cpu, .data_valid, .r_data_cpu,
        .r_req, .r_data_ready, .r_addr, .r_rdy, .ret_valid, .ret_last, .r_data_axi,
        .w_req, .w_data_req, .w_last, .b_ready, .w_addr, .w_strb, .w_data_axi,
        .w_rdy, .w_data_ready, .b_valid
    );

    dcache_mem_model u_mem (
        .clk, .rst_n, .r_req, .r_data_ready, .r_addr, .r_rdy, .ret_valid, .ret_last, .r_data_axi,
        .w_req, .w_data_req, .w_last, .b_ready, .w_addr, .w_strb, .w_data_axi,
        .w_rdy, .w_data_ready, .b_valid
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] ref_load(input logic [31:0] a);
        if (ref_mem.exists(a[31:2]))
            return ref_mem[a[31:2]];
        return {a[31:2], 2'b00} ^ 32'h5a5a0000;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input string what, input logic cond);
        checks++;
        assert (cond === 1'b1) else begin
            $display("[ERROR] %0t ns %s", $time, what);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        tests++;
        test_name = name;
        test_err0 = errors;
    endtask

    task automatic end_test();
        if (errors == test_err0) begin
            $display("test %0d %s: ok", tests, test_name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests, test_name, errors - test_err0);
        end
    endtask

    // one CPU request; lat counts cycles from acceptance to data_valid
    task automatic access(input logic wr, input logic [31:0] a, input logic [3:0] be,
                          input logic [31:0] wd, output int lat, output logic rq);
        logic        got;
        logic [31:0] exp;
        got = 1'b0;
        lat = 0;
        rq = 1'b0;
        cur_line = {a[31:6], 6'd0};
        @(posedge clk);
        valid <= 1'b1;
        op <= wr;
        addr <= a;
        write_type <= be;
        w_data_cpu <= wd;
        @(posedge clk);                    // taken in IDLE here
        while (!got && lat < TIMEOUT) begin
            @(posedge clk);
            lat++;
            if (r_req)
                rq = 1'b1;
            got = data_valid;
        end
        valid <= 1'b0;
        check_true("the cache did not answer a request in time", got);
        exp = ref_load(a);
        if (wr) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b])
                    exp[b*8 +: 8] = wd[b*8 +: 8];
            end
            ref_mem[a[31:2]] = exp;
        end else if (got) begin
            check_eq("r_data_cpu", r_data_cpu, exp);
        end
    endtask

    // bus monitor for burst addresses, write-back data and the data_valid pulse
    always @(posedge clk) begin
        if (rst_n) begin
            if (r_req && r_rdy)
                check_eq("r_addr", r_addr, cur_line);
            if (w_req && w_rdy) begin
                check_eq("w_addr[5:0]", 32'(w_addr[5:0]), 32'd0);
                wb_base = w_addr;
                wb_beat = 0;
                wb_count++;
            end
            if (w_data_req && w_data_ready) begin
                check_eq("w_data_axi", w_data_axi, ref_load(wb_base + 32'(wb_beat) * 4));
                check_eq("w_strb", 32'(w_strb), 32'hf);
                check_eq("w_last", 32'(w_last), 32'(wb_beat == 15));
                wb_beat++;
            end
            if (b_ready && b_valid)
                check_eq("write beats", 32'(wb_beat), 32'd16);
            check_true("data_valid stayed high for two cycles", !(data_valid && dv_q));
            dv_q = data_valid;
        end
    end

    initial begin
        logic [31:0] a;
        int          lat;
        logic        rq;
        int          wb0;
        void'($urandom(32'h24f3d611));
        rst_n = 1'b0;
        valid = 1'b0;
        op = 1'b0;
        addr = '0;
        write_type = '0;
        w_data_cpu = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        begin_test("reset and first miss");
        check_eq("{data_valid,r_req,r_data_ready,w_req,w_data_req,w_last,b_ready}",
                 32'({data_valid, r_req, r_data_ready, w_req, w_data_req, w_last, b_ready}), 0);
        access(1'b0, {20'h00100, 6'd1, 4'd7, 2'b00}, 4'h0, 32'h0, lat, rq);
        check_true("first read issued no r_req", rq);
        check_true("first read was answered like a hit", lat > 1);
        end_test();

        begin_test("read hit latency");
        access(1'b0, {20'h00100, 6'd1, 4'd7, 2'b00}, 4'h0, 32'h0, lat, rq);
        check_eq("data_valid latency", 32'(lat), 32'd1);
        check_true("read hit issued r_req", !rq);
        access(1'b0, {20'h00100, 6'd1, 4'd3, 2'b00}, 4'h0, 32'h0, lat, rq);
        check_eq("data_valid latency", 32'(lat), 32'd1);
        end_test();

        begin_test("byte-enable write hit");
        access(1'b0, {20'h00300, 6'd3, 6'd0}, 4'h0, 32'h0, lat, rq);    // fill the line
        for (int k = 0; k < 10; k++) begin
            a = {20'h00300, 6'd3, 4'($urandom_range(3, 0)), 2'b00};
            access(1'b1, a, 4'($urandom_range(15, 0)), $urandom, lat, rq);
            check_eq("write hit latency", 32'(lat), 32'd1);
        end
        for (int k = 0; k < 4; k++)
            access(1'b0, {20'h00300, 6'd3, 4'(k), 2'b00}, 4'h0, 32'h0, lat, rq);
        end_test();

        begin_test("dirty eviction");
        wb0 = wb_count;
        for (int t = 0; t < 5; t++)
            access(1'b1, {20'h00a00 + 20'(t), 6'd5, 4'(t), 2'b00}, 4'hf, $urandom, lat, rq);
        check_true("five tags in one set caused no write-back", wb_count > wb0);
        check_true("write-back address is not a dirty line of the set",
                   wb_base[31:12] >= 20'h00a00 && wb_base[31:12] < 20'h00a04 &&
                   wb_base[11:0] == {6'd5, 6'd0});
        for (int t = 0; t < 5; t++)
            access(1'b0, {20'h00a00 + 20'(t), 6'd5, 4'(t), 2'b00}, 4'h0, 32'h0, lat, rq);
        end_test();

        begin_test("pseudo-LRU victim");
        for (int t = 0; t < 4; t++)
            access(1'b1, {20'h00b00 + 20'(t), 6'd9, 6'd0}, 4'hf, $urandom, lat, rq);
        access(1'b0, {20'h00b00, 6'd9, 6'd0}, 4'h0, 32'h0, lat, rq);   // touch the oldest
        check_eq("data_valid latency", 32'(lat), 32'd1);
        wb0 = wb_count;
        access(1'b0, {20'h00b04, 6'd9, 6'd0}, 4'h0, 32'h0, lat, rq);
        check_true("miss to a full dirty set wrote back no line", wb_count == wb0 + 1);
        check_true("the line just reread was evicted", wb_base != {20'h00b00, 6'd9, 6'd0});
        end_test();

        begin_test("random traffic with back-pressure");
        for (int i = 0; i < 300; i++) begin
            a = {20'h00c00 + 20'($urandom_range(5, 0)), 6'd17 + 6'($urandom_range(2, 0)),
                 4'($urandom_range(15, 0)), 2'b00};
            access(1'($urandom_range(1, 0)), a, 4'($urandom_range(15, 0)), $urandom, lat, rq);
        end
        end_test();

        $display("%0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
                 tests, tests - tests_failed, tests_failed, checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/dcache_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_model (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        r_req,
    input  wire logic        r_data_ready,
    input  wire logic [31:0] r_addr,
    output logic             r_rdy,
    output logic             ret_valid,
    output logic             ret_last,
    output logic [31:0]      r_data_axi,
    input  wire logic        w_req,
    input  wire logic        w_data_req,
    input  wire logic        w_last,
    input  wire logic        b_ready,
    input  wire logic [31:0] w_addr,
    input  wire logic [3:0]  w_strb,
    input  wire logic [31:0] w_data_axi,
    output logic             w_rdy,
    output logic             w_data_ready,
    output logic             b_valid
);
    logic [31:0] mem [logic [29:0]];   // sparse backing store, word addressed
    logic [31:0] rd_base;
    logic [31:0] wr_base;
    logic [3:0]  rd_beat;
    logic [3:0]  wr_beat;
    logic [1:0]  rd_gap;               // idle cycles before the next ready
    logic [1:0]  wr_gap;
    logic        rd_busy;
    logic        b_pending;

    // untouched words hold their own address XOR the pattern
    function automatic logic [31:0] load(input logic [31:0] a);
        if (mem.exists(a[31:2]))
            return mem[a[31:2]];
        return {a[31:2], 2'b00} ^ 32'h5a5a0000;
    endfunction

    task automatic store(input logic [31:0] a, input logic [31:0] d, input logic [3:0] strb);
        logic [31:0] word;
        word = load(a);
        for (int b = 0; b < 4; b++) begin
            if (strb[b])
                word[b*8 +: 8] = d[b*8 +: 8];
        end
        mem[a[31:2]] = word;
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_rdy <= 1'b0;
            ret_valid <= 1'b0;
            ret_last <= 1'b0;
            r_data_axi <= '0;
            rd_base <= '0;
            rd_beat <= '0;
            rd_gap <= '0;
            rd_busy <= 1'b0;
        end else begin
            r_rdy <= 1'b0;
            ret_valid <= 1'b0;
            ret_last <= 1'b0;
            if (r_rdy && r_req) begin              // address taken
                rd_busy <= 1'b1;
                rd_base <= r_addr;
                rd_beat <= '0;
                rd_gap <= 2'($urandom_range(3, 0));
            end else if (ret_valid) begin          // beat taken
                rd_beat <= rd_beat + 1'b1;
                rd_busy <= !ret_last;
                rd_gap <= 2'($urandom_range(3, 0));
            end else if (rd_gap != 0) begin
                rd_gap <= rd_gap - 1'b1;
            end else if (!rd_busy && r_req) begin
                r_rdy <= 1'b1;
            end else if (rd_busy && r_data_ready) begin
                ret_valid <= 1'b1;
                ret_last <= (rd_beat == 4'd15);
                r_data_axi <= load(rd_base + 32'(rd_beat) * 4);
            end
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            w_rdy <= 1'b0;
            w_data_ready <= 1'b0;
            b_valid <= 1'b0;
            wr_base <= '0;
            wr_beat <= '0;
            wr_gap <= '0;
            b_pending <= 1'b0;
        end else begin
            w_rdy <= 1'b0;
            w_data_ready <= 1'b0;
            b_valid <= 1'b0;
            if (w_rdy && w_req) begin
                wr_base <= w_addr;
                wr_beat <= '0;
                wr_gap <= 2'($urandom_range(3, 0));
            end else if (w_data_ready && w_data_req) begin
                store(wr_base + 32'(wr_beat) * 4, w_data_axi, w_strb);
                wr_beat <= wr_beat + 1'b1;
                b_pending <= w_last;
                wr_gap <= 2'($urandom_range(3, 0));
            end else if (b_valid && b_ready) begin
                b_pending <= 1'b0;
                wr_gap <= 2'($urandom_range(3, 0));
            end else if (wr_gap != 0) begin
                wr_gap <= wr_gap - 1'b1;
            end else if (w_req) begin
                w_rdy <= 1'b1;
            end else if (w_data_req && !b_pending) begin
                w_data_ready <= 1'b1;
            end else if (b_pending && b_ready) begin
                b_valid <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/dcache.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    // CPU side
    input  wire logic                   valid,
    input  wire logic                   op,           // 1 = write
    input  wire logic [`DC_WORD_W-1:0]  addr,
    input  wire logic [`DC_BE_W-1:0]    write_type,   // byte enables
    input  wire logic [`DC_WORD_W-1:0]  w_data_cpu,
    output logic                        data_valid,
    output logic [`DC_WORD_W-1:0]       r_data_cpu,
    // read burst
    output logic                        r_req,
    output logic                        r_data_ready,
    output logic [`DC_WORD_W-1:0]       r_addr,
    input  wire logic                   r_rdy,
    input  wire logic                   ret_valid,
    input  wire logic                   ret_last,
    input  wire logic [`DC_WORD_W-1:0]  r_data_axi,
    // write burst
    output logic                        w_req,
    output logic                        w_data_req,
    output logic                        w_last,
    output logic                        b_ready,
    output logic [`DC_WORD_W-1:0]       w_addr,
    output logic [`DC_BE_W-1:0]         w_strb,
    output logic [`DC_WORD_W-1:0]       w_data_axi,
    input  wire logic                   w_rdy,
    input  wire logic                   w_data_ready,
    input  wire logic                   b_valid
);
    import dcache_mem_pkg::*;

    logic [`DC_IDX_W-1:0]          rd_index;
    logic [`DC_IDX_W-1:0]          wr_index;
    logic [`DC_WAYS-1:0]           wr_way;
    dc_line_t                      wr_line;
    logic [`DC_LINE_BYTES-1:0]     wr_byte_en;
    logic                          tag_we;
    logic [`DC_TAG_W-1:0]          wr_tag;
    logic                          wr_dirty;
    logic                          lru_touch;
    logic [`DC_WAYS-1:0]           hit;
    dc_line_t [`DC_WAYS-1:0]       way_lines;
    logic [1:0]                    victim_way;
    logic [`DC_TAG_W-1:0]          victim_tag;
    logic                          victim_valid;
    logic                          victim_dirty;

    dcache_wb_if u_wb_if ();

    dcache_ctrl u_ctrl (
        .clk, .rst_n, .valid, .op, .addr, .write_type, .w_data_cpu,
        .hit, .way_lines, .victim_way, .victim_tag, .victim_valid, .victim_dirty,
        .r_rdy, .ret_valid, .ret_last, .r_data_axi,
        .rd_index, .wr_index, .wr_way, .wr_line, .wr_byte_en,
        .tag_we, .wr_tag, .wr_dirty, .lru_touch,
        .data_valid, .r_data_cpu, .r_req, .r_data_ready, .r_addr,
        .wb (u_wb_if.ctrl)
    );

    dcache_store u_store (
        .clk, .rst_n, .rd_index, .wr_index, .wr_way, .wr_line, .wr_byte_en,
        .tag_we, .wr_tag, .wr_dirty, .lru_touch,
        .lookup_tag (wr_tag),        // tag of the held request
        .hit, .way_lines, .victim_way, .victim_tag, .victim_valid, .victim_dirty
    );

    dcache_wbuf u_wbuf (
        .clk, .rst_n,
        .wb (u_wb_if.wbuf),
        .w_req, .w_addr, .w_data_req, .w_strb, .w_data_axi, .w_last, .b_ready,
        .w_rdy, .w_data_ready, .b_valid
    );

endmodule

`default_nettype wire

// File: design/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_ctrl (
    input  wire logic                                    clk,
    input  wire logic                                    rst_n,
    input  wire logic                                    valid,
    input  wire logic                                    op,
    input  dcache_cpu_pkg::dc_addr_u                     addr,
    input  wire logic [`DC_BE_W-1:0]                     write_type,
    input  wire logic [`DC_WORD_W-1:0]                   w_data_cpu,
    input  wire logic [`DC_WAYS-1:0]                     hit,
    input  dcache_mem_pkg::dc_line_t [`DC_WAYS-1:0]      way_lines,
    input  wire logic [1:0]                              victim_way,
    input  wire logic [`DC_TAG_W-1:0]                    victim_tag,
    input  wire logic                                    victim_valid,
    input  wire logic                                    victim_dirty,
    input  wire logic                                    r_rdy,
    input  wire logic                                    ret_valid,
    input  wire logic                                    ret_last,
    input  wire logic [`DC_WORD_W-1:0]                   r_data_axi,
    output logic [`DC_IDX_W-1:0]                         rd_index,
    output logic [`DC_IDX_W-1:0]                         wr_index,
    output logic [`DC_WAYS-1:0]                          wr_way,
    output dcache_mem_pkg::dc_line_t                     wr_line,
    output logic [`DC_LINE_BYTES-1:0]                    wr_byte_en,
    output logic                                         tag_we,
    output logic [`DC_TAG_W-1:0]                         wr_tag,
    output logic                                         wr_dirty,
    output logic                                         lru_touch,
    output logic                                         data_valid,
    output logic [`DC_WORD_W-1:0]                        r_data_cpu,
    output logic                                         r_req,
    output logic                                         r_data_ready,
    output logic [`DC_WORD_W-1:0]                        r_addr,
    dcache_wb_if.ctrl                                    wb
);
    import dcache_cpu_pkg::*;
    import dcache_mem_pkg::*;

    dc_state_e  state;
    dc_req_t    req;          // request buffer
    logic [1:0] mb_way;       // miss buffer
    dc_addr_u   mb_addr;
    logic       mb_wb;        // victim needs write-back
    dc_line_t   ret_buf;      // refill beats shift in from the top
    dc_line_t   merged;
    dc_line_t   hit_line;
    dc_addr_u   fill_addr;
    logic       lookup_hit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:       if (valid) state <= LOOKUP;
                LOOKUP:     state <= lookup_hit ? IDLE : MISS;
                MISS:       state <= mb_wb ? WRITEBACK : REFILL_REQ;
                WRITEBACK:  if (wb.done) state <= REFILL_REQ;
                REFILL_REQ: if (r_rdy) state <= REFILL;
                REFILL:     if (ret_valid && ret_last) state <= REPLAY;
                REPLAY:     state <= IDLE;
                default:    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && valid) begin
            req.addr <= addr;
            req.op <= op;
            req.be <= write_type;
            req.wdata <= w_data_cpu;
        end
        if (state == LOOKUP) begin
            mb_way <= victim_way;
            mb_wb <= victim_valid && victim_dirty;
            mb_addr.f.tag <= victim_tag;
            mb_addr.f.index <= req.addr.f.index;
            mb_addr.f.word <= '0;
            mb_addr.f.byte_off <= '0;
        end
        if (state == REFILL && ret_valid)
            ret_buf <= {r_data_axi, ret_buf[`DC_LINE_WORDS-1:1]};
    end

    assign lookup_hit = (state == LOOKUP) && |hit;

    // CPU bytes laid over the refilled line; on a write hit only these lanes are enabled
    always_comb begin
        merged = ret_buf;
        for (int b = 0; b < `DC_BE_W; b++) begin
            if (req.op && req.be[b])
                merged[req.addr.f.word][b*8 +: 8] = req.wdata[b*8 +: 8];
        end
    end

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (hit[w])
                hit_line = way_lines[w];
        end
    end

    always_comb begin
        wr_way = '0;
        wr_byte_en = '0;
        if (lookup_hit) begin
            wr_way = hit;
            if (req.op)
                wr_byte_en[req.addr.f.word*`DC_BE_W +: `DC_BE_W] = req.be;
        end else if (state == REPLAY) begin
            wr_way[mb_way] = 1'b1;
            wr_byte_en = '1;
        end
    end

    always_comb begin
        fill_addr = req.addr;
        fill_addr.f.word = '0;
        fill_addr.f.byte_off = '0;
    end

    // same index through the whole miss keeps the array outputs stable
    assign rd_index     = (state == IDLE) ? addr.f.index : req.addr.f.index;
    assign wr_index     = req.addr.f.index;
    assign wr_line      = merged;
    assign tag_we       = (state == REPLAY);
    assign wr_tag       = req.addr.f.tag;      // also the lookup tag
    assign wr_dirty     = req.op;
    assign lru_touch    = lookup_hit || tag_we;
    assign data_valid   = lru_touch;
    assign r_data_cpu   = tag_we ? merged[req.addr.f.word] : hit_line[req.addr.f.word];
    assign r_req        = (state == REFILL_REQ);
    assign r_data_ready = (state == REFILL);
    assign r_addr       = fill_addr.raw;

    assign wb.start = (state == MISS) && mb_wb;
    assign wb.line  = way_lines[mb_way];
    assign wb.addr  = mb_addr;

endmodule

`default_nettype wire

// File: design/dcache_wbuf.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_wbuf (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    dcache_wb_if.wbuf                   wb,
    output logic                        w_req,
    output logic [`DC_WORD_W-1:0]       w_addr,
    output logic                        w_data_req,
    output logic [`DC_BE_W-1:0]         w_strb,
    output logic [`DC_WORD_W-1:0]       w_data_axi,
    output logic                        w_last,
    output logic                        b_ready,
    input  wire logic                   w_rdy,
    input  wire logic                   w_data_ready,
    input  wire logic                   b_valid
);
    import dcache_cpu_pkg::*;
    import dcache_mem_pkg::*;

    typedef enum logic [1:0] {WB_IDLE, WB_ADDR, WB_DATA, WB_RESP} wb_phase_e;

    wb_phase_e                            phase;
    logic [$clog2(`DC_LINE_WORDS)-1:0]    beat;
    dc_line_t                             line_q;
    dc_addr_u                             addr_q;

    always_ff @(posedge clk) begin
        if (phase == WB_IDLE && wb.start) begin
            line_q <= wb.line;
            addr_q <= wb.addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= WB_IDLE;
            beat <= '0;
        end else begin
            case (phase)
                WB_IDLE: if (wb.start) phase <= WB_ADDR;
                WB_ADDR: begin
                    beat <= '0;
                    if (w_rdy) phase <= WB_DATA;
                end
                WB_DATA: begin
                    if (w_data_ready) begin
                        beat <= beat + 1'b1;
                        if (w_last) phase <= WB_RESP;
                    end
                end
                WB_RESP: if (b_valid) phase <= WB_IDLE;
                default: phase <= WB_IDLE;
            endcase
        end
    end

    assign w_req      = (phase == WB_ADDR);
    assign w_addr     = addr_q.raw;
    assign w_data_req = (phase == WB_DATA);
    assign w_strb     = '1;                   // whole-line write-back
    assign w_data_axi = line_q[beat];
    assign w_last     = w_data_req && (beat == `DC_LINE_WORDS - 1);
    assign b_ready    = (phase == WB_RESP);
    assign wb.done    = b_ready && b_valid;

endmodule

`default_nettype wire

// File: design/dcache_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_store (
    input  wire logic                                    clk,
    input  wire logic                                    rst_n,
    input  wire logic [`DC_IDX_W-1:0]                    rd_index,
    input  wire logic [`DC_IDX_W-1:0]                    wr_index,
    input  wire logic [`DC_WAYS-1:0]                     wr_way,      // one-hot
    input  dcache_mem_pkg::dc_line_t                     wr_line,
    input  wire logic [`DC_LINE_BYTES-1:0]               wr_byte_en,
    input  wire logic                                    tag_we,
    input  wire logic [`DC_TAG_W-1:0]                    wr_tag,
    input  wire logic                                    wr_dirty,
    input  wire logic                                    lru_touch,   // touched way is wr_way
    input  wire logic [`DC_TAG_W-1:0]                    lookup_tag,
    output logic [`DC_WAYS-1:0]                          hit,
    output dcache_mem_pkg::dc_line_t [`DC_WAYS-1:0]      way_lines,
    output logic [1:0]                                   victim_way,
    output logic [`DC_TAG_W-1:0]                         victim_tag,
    output logic                                         victim_valid,
    output logic                                         victim_dirty
);
    import dcache_mem_pkg::*;

    dc_line_t             data_mem [`DC_WAYS][`DC_SETS];
    logic [`DC_TAG_W-1:0] tag_mem  [`DC_WAYS][`DC_SETS];
    logic [`DC_TAG_W-1:0] tag_q    [`DC_WAYS];
    logic [`DC_WAYS-1:0]  valid_r  [`DC_SETS];
    logic [`DC_WAYS-1:0]  dirty_r  [`DC_SETS];
    logic [2:0]           lru_r    [`DC_SETS];  // [0] root, [1] ways 0/1, [2] ways 2/3
    logic [`DC_IDX_W-1:0] idx_q;                // index of the last array read
    logic [1:0]           touch_way;

    // synchronous-read data and tag arrays
    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            for (int b = 0; b < `DC_LINE_BYTES; b++) begin
                if (wr_way[w] && wr_byte_en[b])
                    data_mem[w][wr_index][b/4][(b%4)*8 +: 8] <= wr_line[b/4][(b%4)*8 +: 8];
            end
            if (wr_way[w] && tag_we)
                tag_mem[w][wr_index] <= wr_tag;
            way_lines[w] <= data_mem[w][rd_index];
            tag_q[w] <= tag_mem[w][rd_index];
        end
    end

    always_comb begin
        touch_way = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (wr_way[w])
                touch_way = 2'(w);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_q <= '0;
            for (int s = 0; s < `DC_SETS; s++) begin
                valid_r[s] <= '0;
                dirty_r[s] <= '0;
                lru_r[s] <= '0;
            end
        end else begin
            idx_q <= rd_index;
            if (tag_we)
                valid_r[wr_index] <= valid_r[wr_index] | wr_way;
            // dirty follows every line write
            if (tag_we || |wr_byte_en) begin
                for (int w = 0; w < `DC_WAYS; w++) begin
                    if (wr_way[w])
                        dirty_r[wr_index][w] <= wr_dirty;
                end
            end
            // point the tree away from the touched way
            if (lru_touch) begin
                lru_r[wr_index][0] <= ~touch_way[1];
                if (touch_way[1])
                    lru_r[wr_index][2] <= ~touch_way[0];
                else
                    lru_r[wr_index][1] <= ~touch_way[0];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++)
            hit[w] = valid_r[idx_q][w] && (tag_q[w] == lookup_tag);
    end

    // first invalid way wins over the tree
    always_comb begin
        if (lru_r[idx_q][0])
            victim_way = {1'b1, lru_r[idx_q][2]};
        else
            victim_way = {1'b0, lru_r[idx_q][1]};
        for (int w = `DC_WAYS-1; w >= 0; w--) begin
            if (!valid_r[idx_q][w])
                victim_way = 2'(w);
        end
    end

    assign victim_tag   = tag_q[victim_way];
    assign victim_valid = valid_r[idx_q][victim_way];
    assign victim_dirty = dirty_r[idx_q][victim_way];

endmodule

`default_nettype wire

// File: design/dcache_wb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dcache_wb_if;
    import dcache_cpu_pkg::*;
    import dcache_mem_pkg::*;

    logic     start;    // one-cycle job pulse
    dc_line_t line;     // victim line
    dc_addr_u addr;     // victim line address
    logic     done;     // pulse after write response

    modport ctrl (
        output start, line, addr,
        input  done
    );

    modport wbuf (
        input  start, line, addr,
        output done
    );

endinterface

`default_nettype wire

// File: design/dcache_mem_pkg.sv
`default_nettype none

`include "dcache_defs.svh"

package dcache_mem_pkg;

    // word 0 sits in the low bits
    typedef logic [`DC_LINE_WORDS-1:0][`DC_WORD_W-1:0] dc_line_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        WRITEBACK,
        REFILL_REQ,
        REFILL,
        REPLAY
    } dc_state_e;

endpackage

`default_nettype wire

// File: design/dcache_cpu_pkg.sv
`default_nettype none

`include "dcache_defs.svh"

package dcache_cpu_pkg;

    // word offset plus byte offset make up the line offset
    typedef struct packed {
        logic [`DC_TAG_W-1:0]   tag;
        logic [`DC_IDX_W-1:0]   index;
        logic [`DC_OFF_W-3:0]   word;
        logic [1:0]             byte_off;
    } dc_addr_fields_t;

    typedef union packed {
        logic [`DC_WORD_W-1:0]  raw;
        dc_addr_fields_t        f;
    } dc_addr_u;

    typedef struct packed {
        dc_addr_u               addr;
        logic                   op;      // 1 = write
        logic [`DC_BE_W-1:0]    be;
        logic [`DC_WORD_W-1:0]  wdata;
    } dc_req_t;

endpackage

`default_nettype wire

// File: design/dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// cache geometry
`define DC_WAYS        4
`define DC_SETS        64
`define DC_LINE_WORDS  16

// address split, tag | index | offset
`define DC_TAG_W       20
`define DC_IDX_W       6
`define DC_OFF_W       6

// data path
`define DC_WORD_W      32
`define DC_BE_W        (`DC_WORD_W / 8)
`define DC_LINE_BYTES  (`DC_LINE_WORDS * `DC_BE_W)

`endif
